//--- build.f
ldpcPkg.sv
decoderConfig.sv
variableNodeArray.sv
checkNodeArray.sv
iterationControl.sv
ldpcDecoder.sv
ldpcDecoder_chk.sv
ldpcDecoder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the decoder testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module ldpcDecoder_tb -f build.f; then
	echo "Verilator build failed."
	exit 1
fi

simOutput=$(./obj_dir/VldpcDecoder_tb +verilator+error+limit+1000)
simStatus=$?
printf '%s\n' "$simOutput"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus."
	exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "Testbench passed"; then
	exit 0
fi

echo "Pass line not found in the simulation output."
exit 1

//--- ldpcDecoder_tb.sv
`timescale 1ns/100ps

module ldpcDecoder_tb;

	import ldpcPkg::*;

	localparam int clkPeriod = 10;
	localparam int resetCycles = 3;
	localparam int maxIterCap = 8;
	localparam int numConverge = 20;
	localparam int numRandom = 40;
	localparam int numZeroLimit = 4;
	localparam int numSaturate = 20;
	localparam int numRestart = 8;
	localparam int numDecodes = numConverge + numRandom + numZeroLimit + numSaturate
		+ 2 * numRestart;
	// each decode ends within 2 * maxIter + 4 cycles.
	localparam int watchdogCycles = resetCycles + numDecodes * (2 * maxIterCap + 4) + 100;

	// range of a signed llrWidth word.
	localparam longint maxLlr = (longint'(1) << (llrWidth - 1)) - 1;
	localparam longint minLlr = -(longint'(1) << (llrWidth - 1));

	logic clk;
	logic reset;
	logic start;
	logic [numVar-1:0][llrWidth-1:0] llrs;
	logic [iterWidth-1:0] maxIter;
	logic [numVar-1:0] result;
	logic [statusWidth-1:0] status;
	logic [iterWidth-1:0] iterations;

	int errorCount;
	longint chanLlr [numVar];

	ldpcDecoder i_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.llrs(llrs),
		.maxIter(maxIter),
		.result(result),
		.status(status),
		.iterations(iterations)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout: the decoder did not finish within %0d cycles.", watchdogCycles);
		$display("Testbench failed");
		$finish;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errorCount++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic longint clampLlr(input longint value);
		if (value > maxLlr) begin
			return maxLlr;
		end else if (value < minLlr) begin
			return minLlr;
		end
		return value;
	endfunction

	function automatic logic [numCheck-1:0] syndromeOf(input logic [numVar-1:0] bits);
		logic [numCheck-1:0] syn;
		for (int i = 0; i < numCheck; i++) begin
			syn[i] = 1'b0;
			for (int j = 0; j < numVar; j++) begin
				if (parityMatrix[i][j] && bits[j]) begin
					syn[i] = ~syn[i];
				end
			end
		end
		return syn;
	endfunction

	// returns a sign pattern that every check accepts or zero if none is found.
	function automatic logic [numVar-1:0] validPattern();
		logic [31:0] r;
		logic [numVar-1:0] bits;
		for (int t = 0; t < 64; t++) begin
			r = $urandom;
			bits = r[numVar-1:0];
			if (syndromeOf(bits) == '0) begin
				return bits;
			end
		end
		return '0;
	endfunction

	function automatic logic [numVar-1:0] oddPattern();
		logic [31:0] r;
		logic [numVar-1:0] bits;
		r = $urandom;
		bits = r[numVar-1:0];
		if (!(^bits)) begin
			bits[0] = ~bits[0];
		end
		return bits;
	endfunction

	// nonzero magnitudes up to 16.0 in the fixed-point format.
	task automatic fillChannel(input logic [numVar-1:0] signs);
		longint mag;
		for (int j = 0; j < numVar; j++) begin
			mag = longint'($urandom_range(16 << fracBits, 1));
			chanLlr[j] = signs[j] ? -mag : mag;
		end
	endtask

	task automatic fillSaturated(input logic [numVar-1:0] signs);
		for (int j = 0; j < numVar; j++) begin
			chanLlr[j] = signs[j] ? minLlr : maxLlr;
		end
	endtask

	// min-sum reference model with one loop pass per variable phase.
	task automatic predictDecode(input int limitValue, output logic [numVar-1:0] expResult,
		output logic [statusWidth-1:0] expStatus, output int expIter);
		longint c2v [numCheck][numVar];
		longint v2c [numCheck][numVar];
		longint belief [numVar];
		longint sum;
		longint mag;
		longint minMag;
		logic [numVar-1:0] hard;
		logic negative;
		bit done;
		for (int i = 0; i < numCheck; i++) begin
			for (int j = 0; j < numVar; j++) begin
				c2v[i][j] = 0;
				v2c[i][j] = 0;
			end
		end
		expIter = 0;
		done = 1'b0;
		while (!done) begin
			for (int j = 0; j < numVar; j++) begin
				sum = chanLlr[j];
				for (int i = 0; i < numCheck; i++) begin
					if (parityMatrix[i][j]) begin
						sum = sum + c2v[i][j];
					end
				end
				belief[j] = clampLlr(sum);
				hard[j] = (belief[j] < 0);
			end
			if (syndromeOf(hard) == '0) begin
				expStatus = statusConverged;
				done = 1'b1;
			end else if (expIter == limitValue) begin
				expStatus = statusLimit;
				done = 1'b1;
			end else begin
				for (int i = 0; i < numCheck; i++) begin
					for (int j = 0; j < numVar; j++) begin
						v2c[i][j] = parityMatrix[i][j] ? clampLlr(belief[j] - c2v[i][j]) : 0;
					end
				end
				for (int i = 0; i < numCheck; i++) begin
					for (int j = 0; j < numVar; j++) begin
						minMag = maxLlr;
						negative = 1'b0;
						for (int k = 0; k < numVar; k++) begin
							if (k != j && parityMatrix[i][k]) begin
								mag = (v2c[i][k] < 0) ? -v2c[i][k] : v2c[i][k];
								if (mag > maxLlr) begin
									mag = maxLlr;
								end
								if (mag < minMag) begin
									minMag = mag;
								end
								if (v2c[i][k] < 0) begin
									negative = ~negative;
								end
							end
						end
						if (!parityMatrix[i][j]) begin
							c2v[i][j] = 0;
						end else begin
							c2v[i][j] = negative ? -minMag : minMag;
						end
					end
				end
				expIter++;
			end
		end
		expResult = hard;
	endtask

	// called at a falling edge and returns at the falling edge after the start edge.
	task automatic pulseStart(input int limitValue);
		for (int j = 0; j < numVar; j++) begin
			llrs[j] = chanLlr[j][llrWidth-1:0];
		end
		maxIter = limitValue[iterWidth-1:0];
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// the decode stops at edge 1 + 2k after the start edge.
	task automatic awaitAndCheck(input string name, input int limitValue);
		logic [numVar-1:0] expResult;
		logic [statusWidth-1:0] expStatus;
		int expIter;
		int n;
		predictDecode(limitValue, expResult, expStatus, expIter);
		for (n = 0; n < 2 * expIter + 1; n++) begin
			if (status != statusIdle) begin
				errorCount++;
				$display("%s: status went nonzero too early, %0d cycles after start.",
					name, n);
			end
			@(negedge clk);
		end
		checkValue({name, " result"}, 32'(expResult), 32'(result));
		checkValue({name, " status"}, 32'(expStatus), 32'(status));
		checkValue({name, " iterations"}, 32'(expIter), 32'(iterations));
	endtask

	task automatic decodeAndCheck(input string name, input int limitValue);
		pulseStart(limitValue);
		awaitAndCheck(name, limitValue);
	endtask

	initial begin
		logic [numVar-1:0] signs;
		logic [31:0] r;
		int limitValue;
		errorCount = 0;
		void'($urandom(95));
		reset = 1'b1;
		start = 1'b0;
		llrs = '0;
		maxIter = '0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		checkValue("reset status", 32'(statusIdle), 32'(status));
		checkValue("reset iterations", 32'd0, 32'(iterations));
		checkValue("reset result", 32'd0, 32'(result));

		// sign patterns that already satisfy every check.
		for (int n = 0; n < numConverge; n++) begin
			signs = validPattern();
			fillChannel(signs);
			limitValue = $urandom_range(maxIterCap, 0);
			decodeAndCheck("converge", limitValue);
			checkValue("converge fixed status", 32'(statusConverged), 32'(status));
			checkValue("converge fixed iterations", 32'd0, 32'(iterations));
			checkValue("converge fixed result", 32'(signs), 32'(result));
		end

		for (int n = 0; n < numRandom; n++) begin
			signs = oddPattern();
			fillChannel(signs);
			limitValue = $urandom_range(maxIterCap, 1);
			decodeAndCheck("random", limitValue);
		end

		for (int n = 0; n < numZeroLimit; n++) begin
			signs = oddPattern();
			fillChannel(signs);
			decodeAndCheck("zero limit", 0);
			if (syndromeOf(signs) != '0) begin
				checkValue("zero limit fixed status", 32'(statusLimit), 32'(status));
				checkValue("zero limit fixed iterations", 32'd0, 32'(iterations));
			end
		end

		// full-scale LLRs drive the sums and magnitudes into saturation.
		for (int n = 0; n < numSaturate; n++) begin
			r = $urandom;
			signs = r[numVar-1:0];
			fillSaturated(signs);
			limitValue = $urandom_range(maxIterCap, 1);
			decodeAndCheck("saturate", limitValue);
		end

		// second start lands on the first decode's check pass.
		for (int n = 0; n < numRestart; n++) begin
			fillChannel(oddPattern());
			pulseStart(maxIterCap);
			@(negedge clk);
			fillChannel(oddPattern());
			limitValue = $urandom_range(maxIterCap, 1);
			decodeAndCheck("restart", limitValue);
		end

		errorCount += i_dut.i_chk.idleFails + i_dut.i_chk.limitFails + i_dut.i_chk.holdFails;
		$display("Checks finished with %0d errors.", errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- ldpcDecoder_chk.sv
`timescale 1ns/100ps

module ldpcDecoder_chk (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [ldpcPkg::statusWidth-1:0] status,
	input logic [ldpcPkg::iterWidth-1:0] iterations,
	input logic [ldpcPkg::iterWidth-1:0] limit
);

	import ldpcPkg::*;

	int idleFails = 0;
	int limitFails = 0;
	int holdFails = 0;

	// a start clears the previous outcome.
	startClears: assert property (@(posedge clk) disable iff (reset)
		start |=> status == statusIdle)
	else begin
		idleFails++;
		$error("status is not idle in the cycle after start");
	end

	iterWithinLimit: assert property (@(posedge clk) disable iff (reset)
		iterations <= limit)
	else begin
		limitFails++;
		$error("iteration count %0d is above the limit %0d", iterations, limit);
	end

	// a finished decode holds its status until the next start.
	statusHolds: assert property (@(posedge clk) disable iff (reset)
		(status != statusIdle && !start) |=> $stable(status))
	else begin
		holdFails++;
		$error("status changed while the decoder was idle");
	end

endmodule

bind ldpcDecoder ldpcDecoder_chk i_chk (
	.clk(clk),
	.reset(reset),
	.start(start),
	.status(status),
	.iterations(iterations),
	.limit(limit)
);

//--- ldpcDecoder.sv
`timescale 1ns/100ps

module ldpcDecoder (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] llrs,
	input  logic [ldpcPkg::iterWidth-1:0] maxIter,
	output logic [ldpcPkg::numVar-1:0] result,
	output logic [ldpcPkg::statusWidth-1:0] status,
	output logic [ldpcPkg::iterWidth-1:0] iterations
);

	import ldpcPkg::*;

	logic [numVar-1:0][llrWidth-1:0] channelLlrs;
	logic [iterWidth-1:0] limit;
	logic clearMsgs;
	logic varPhase;
	logic checkPhase;
	logic [numCheck-1:0][numVar-1:0][llrWidth-1:0] varToCheck;
	logic [numCheck-1:0][numVar-1:0][llrWidth-1:0] checkToVar;
	logic [numVar-1:0] decisions;

	decoderConfig i_decoderConfig (
		.clk(clk),
		.reset(reset),
		.start(start),
		.llrs(llrs),
		.maxIter(maxIter),
		.channelLlrs(channelLlrs),
		.limit(limit)
	);

	variableNodeArray i_variableNodeArray (
		.clk(clk),
		.reset(reset),
		.clearMsgs(clearMsgs),
		.varPhase(varPhase),
		.channelLlrs(channelLlrs),
		.checkToVar(checkToVar),
		.varToCheck(varToCheck),
		.decisions(decisions)
	);

	checkNodeArray i_checkNodeArray (
		.clk(clk),
		.reset(reset),
		.clearMsgs(clearMsgs),
		.checkPhase(checkPhase),
		.varToCheck(varToCheck),
		.checkToVar(checkToVar)
	);

	iterationControl i_iterationControl (
		.clk(clk),
		.reset(reset),
		.start(start),
		.limit(limit),
		.decisions(decisions),
		.clearMsgs(clearMsgs),
		.varPhase(varPhase),
		.checkPhase(checkPhase),
		.result(result),
		.status(status),
		.iterations(iterations)
	);

endmodule

//--- iterationControl.sv
`timescale 1ns/100ps

module iterationControl (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [ldpcPkg::iterWidth-1:0] limit,
	input  logic [ldpcPkg::numVar-1:0] decisions,
	output logic clearMsgs,
	output logic varPhase,
	output logic checkPhase,
	output logic [ldpcPkg::numVar-1:0] result,
	output logic [ldpcPkg::statusWidth-1:0] status,
	output logic [ldpcPkg::iterWidth-1:0] iterations
);

	import ldpcPkg::*;

	// one-hot sequence that is idle when neither is set.
	logic inVar;
	logic inCheck;
	logic [numCheck-1:0] syndrome;
	logic converged;
	logic atLimit;

	always_comb begin
		for (int i = 0; i < numCheck; i++) begin
			syndrome[i] = ^(decisions & parityMatrix[i]);
		end
	end

	assign converged = (syndrome == '0);
	assign atLimit = (iterations == limit);

	// a start restarts the decode, so it overrides any pass in flight.
	assign clearMsgs = start;
	assign varPhase = inVar && !start && !converged && !atLimit;
	assign checkPhase = inCheck && !start;

	always_ff @(posedge clk) begin
		if (reset) begin
			inVar <= 1'b0;
			inCheck <= 1'b0;
			iterations <= '0;
			status <= statusIdle;
			result <= '0;
		end else if (start) begin
			inVar <= 1'b1;
			inCheck <= 1'b0;
			iterations <= '0;
			status <= statusIdle;
		end else if (inVar) begin
			inVar <= 1'b0;
			if (converged) begin
				status <= statusConverged;
				result <= decisions;
			end else if (atLimit) begin
				status <= statusLimit;
				result <= decisions;
			end else begin
				inCheck <= 1'b1;
			end
		end else if (inCheck) begin
			// one full iteration ends with the check pass.
			inCheck <= 1'b0;
			inVar <= 1'b1;
			iterations <= iterations + 1'b1;
		end
	end

endmodule

//--- checkNodeArray.sv
`timescale 1ns/100ps

module checkNodeArray (
	input  logic clk,
	input  logic reset,
	input  logic clearMsgs,
	input  logic checkPhase,
	input  logic [ldpcPkg::numCheck-1:0][ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] varToCheck,
	output logic [ldpcPkg::numCheck-1:0][ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] checkToVar
);

	import ldpcPkg::*;

	logic [numCheck-1:0][numVar-1:0][llrWidth-1:0] magnitude;
	logic [numCheck-1:0][numVar-1:0][llrWidth-1:0] nextMsg;

	// magnitude of each incoming message.
	// the most negative word has no positive twin and saturates.
	always_comb begin
		for (int i = 0; i < numCheck; i++) begin
			for (int j = 0; j < numVar; j++) begin
				if (!varToCheck[i][j][llrWidth-1]) begin
					magnitude[i][j] = varToCheck[i][j];
				end else if (varToCheck[i][j] == llrMin) begin
					magnitude[i][j] = llrMax;
				end else begin
					magnitude[i][j] = -varToCheck[i][j];
				end
			end
		end
	end

	// min-sum takes the smallest other magnitude and the parity of the other signs.
	always_comb begin
		logic [llrWidth-1:0] minMag;
		logic negative;
		for (int i = 0; i < numCheck; i++) begin
			for (int j = 0; j < numVar; j++) begin
				minMag = llrMax;
				negative = 1'b0;
				for (int k = 0; k < numVar; k++) begin
					if (parityMatrix[i][k] && k != j) begin
						if (magnitude[i][k] < minMag) begin
							minMag = magnitude[i][k];
						end
						// zero has a clear sign bit and counts as positive.
						negative = negative ^ varToCheck[i][k][llrWidth-1];
					end
				end
				if (!parityMatrix[i][j]) begin
					nextMsg[i][j] = '0;
				end else if (negative) begin
					nextMsg[i][j] = -minMag;
				end else begin
					nextMsg[i][j] = minMag;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clearMsgs) begin
			checkToVar <= '0;
		end else if (checkPhase) begin
			checkToVar <= nextMsg;
		end
	end

endmodule

//--- variableNodeArray.sv
`timescale 1ns/100ps

module variableNodeArray (
	input  logic clk,
	input  logic reset,
	input  logic clearMsgs,
	input  logic varPhase,
	input  logic [ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] channelLlrs,
	input  logic [ldpcPkg::numCheck-1:0][ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] checkToVar,
	output logic [ldpcPkg::numCheck-1:0][ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] varToCheck,
	output logic [ldpcPkg::numVar-1:0] decisions
);

	import ldpcPkg::*;

	logic [numVar-1:0][llrWidth-1:0] belief;
	logic [numCheck-1:0][numVar-1:0][llrWidth-1:0] nextMsg;

	// clamp a wide signed value into the message range.
	function automatic logic [llrWidth-1:0] saturate(input logic signed [accWidth-1:0] value);
		if (value > llrMax) begin
			return llrMax;
		end else if (value < llrMin) begin
			return llrMin;
		end else begin
			return value[llrWidth-1:0];
		end
	endfunction

	// belief is the channel LLR plus every incoming check message.
	// unconnected pairs are held at zero, so the whole column can be summed.
	always_comb begin
		logic signed [accWidth-1:0] sum;
		for (int j = 0; j < numVar; j++) begin
			sum = $signed(channelLlrs[j]);
			for (int i = 0; i < numCheck; i++) begin
				sum = sum + $signed(checkToVar[i][j]);
			end
			belief[j] = saturate(sum);
			// negative belief means bit 1.
			decisions[j] = belief[j][llrWidth-1];
		end
	end

	// extrinsic message is the belief without the target check's own contribution.
	always_comb begin
		logic signed [accWidth-1:0] diff;
		for (int i = 0; i < numCheck; i++) begin
			for (int j = 0; j < numVar; j++) begin
				diff = $signed(belief[j]) - $signed(checkToVar[i][j]);
				if (parityMatrix[i][j]) begin
					nextMsg[i][j] = saturate(diff);
				end else begin
					nextMsg[i][j] = '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clearMsgs) begin
			varToCheck <= '0;
		end else if (varPhase) begin
			varToCheck <= nextMsg;
		end
	end

endmodule

//--- decoderConfig.sv
`timescale 1ns/100ps

module decoderConfig (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] llrs,
	input  logic [ldpcPkg::iterWidth-1:0] maxIter,
	output logic [ldpcPkg::numVar-1:0][ldpcPkg::llrWidth-1:0] channelLlrs,
	output logic [ldpcPkg::iterWidth-1:0] limit
);

	// channel LLRs and limit stay fixed for the whole decode.
	always_ff @(posedge clk) begin
		if (reset) begin
			channelLlrs <= '0;
			limit <= '0;
		end else if (start) begin
			channelLlrs <= llrs;
			limit <= maxIter;
		end
	end

endmodule

//--- ldpcPkg.sv
package ldpcPkg;

	// code size.
	localparam int numVar = 6;
	localparam int numCheck = 3;

	// fixed-point format of LLRs, messages and beliefs.
	localparam int llrWidth = 20;
	localparam int fracBits = 6;

	// wide enough for a channel LLR plus one message from every check.
	localparam int accWidth = llrWidth + $clog2(numCheck + 1);

	localparam int iterWidth = 20;

	// bit j of row i is set when check i covers code bit j.
	localparam logic [numCheck-1:0][numVar-1:0] parityMatrix = {
		6'b111111,
		6'b111111,
		6'b111111
	};

	// saturation limits of a signed llrWidth word.
	localparam logic signed [llrWidth-1:0] llrMax = {1'b0, {(llrWidth - 1){1'b1}}};
	localparam logic signed [llrWidth-1:0] llrMin = {1'b1, {(llrWidth - 1){1'b0}}};

	localparam int statusWidth = 2;

	// running or never started.
	localparam logic [statusWidth-1:0] statusIdle = 2'b00;
	// syndrome is zero.
	localparam logic [statusWidth-1:0] statusConverged = 2'b10;
	// iteration limit hit with a nonzero syndrome.
	localparam logic [statusWidth-1:0] statusLimit = 2'b01;

endpackage
